//--- hdl/ppu_settings.svh
`ifndef PPU_SETTINGS_SVH
`define PPU_SETTINGS_SVH

// Side of a tile or sprite in pixels, also the rows per tile
`define PPU_TILE_PX 16

// Background tiles per line, 320 pixels
`define PPU_TILES_PER_LINE 20

// Sprites held in OAM, two words each
`define PPU_SPRITES 16

// Sprites drawn per line
`define PPU_SLOTS 4

// Two palettes of four colors
`define PPU_PALETTE_ENTRIES 8

`endif

//--- hdl/ppu_pkg.sv
`include "ppu_settings.svh"

package ppu_pkg;

    // One tile or sprite row, pixel p at bits 2p+1:2p
    typedef logic [2*`PPU_TILE_PX-1:0] gfx_row_t;

    // Tile map entry: palette bit on top, tile id below
    typedef logic [7:0] map_entry_t;

    // OAM word, odd addresses hold coordinates and even addresses attributes
    typedef union packed {
        struct packed {
            logic [15:0] y;
            logic [15:0] x;
        } coord;
        struct packed {
            logic       rsvd_hi;
            logic       flip;       // Horizontal flip
            logic [21:0] rsvd_mid;
            logic       pal;
            logic [6:0] tile;
        } attr;
    } oam_word_u;

    typedef logic [23:0] color_t;  // 8 bits each of R, G, B

endpackage

//--- hdl/sprite_slot_if.sv
`timescale 1ns/1ns
`include "ppu_settings.svh"

// Sprites chosen for the coming line, written in hsync and read in display
interface sprite_slot_if import ppu_pkg::*; ();

    logic [`PPU_SLOTS-1:0] slot_valid;
    logic [15:0]           slot_x [`PPU_SLOTS];
    gfx_row_t              slot_row [`PPU_SLOTS];  // Already in screen order
    logic [`PPU_SLOTS-1:0] slot_pal;
    logic [`PPU_SLOTS-1:0] slot_flip;

    modport source (
        output slot_valid,
        output slot_x,
        output slot_row,
        output slot_pal,
        output slot_flip
    );

    modport sink (
        input slot_valid,
        input slot_x,
        input slot_row,
        input slot_pal,
        input slot_flip
    );

endinterface

//--- hdl/bg_line_fetch.sv
`timescale 1ns/1ns
`include "ppu_settings.svh"

module bg_line_fetch import ppu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [9:0]  vcount,
    input  logic        vblank,
    input  logic        hsync,
    input  logic [31:0] tile_map_data,
    input  logic [31:0] tile_gfx_data,
    input  logic [$clog2(`PPU_TILES_PER_LINE)-1:0] bg_tile_sel,
    output logic [6:0]  tile_map_addr,
    output logic [10:0] tile_gfx_addr,
    output gfx_row_t    bg_row,
    output logic        bg_pal
);

    localparam int NT = `PPU_TILES_PER_LINE;
    localparam int TS = $clog2(`PPU_TILE_PX);
    localparam int WORDS_PER_ROW = NT / 4;  // Four map entries per word

    gfx_row_t      row_tab [NT];
    logic [NT-1:0] pal_tab;

    logic [4:0]  cnt;
    logic [6:0]  map_base;
    logic [1:0]  entry_sel;
    map_entry_t  map_entry;
    logic [4:0]  gfx_tile;
    logic [4:0]  cap_tile;
    logic        line_phase;

    assign line_phase = hsync && !vblank;
    assign map_base   = 7'(vcount[9:TS]) * 7'(WORDS_PER_ROW);

    // At count k the map word for tile k is requested, the graphics row for
    // tile k-2 is requested and the row of tile k-4 arrives
    assign gfx_tile  = cnt - 5'd2;
    assign cap_tile  = cnt - 5'd4;
    assign entry_sel = gfx_tile[1:0];
    assign map_entry = tile_map_data[8*entry_sel +: 8];

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt           <= '0;
            tile_map_addr <= '0;
            tile_gfx_addr <= '0;
        end else if (line_phase) begin
            if (cnt < 5'(NT + 4))
                cnt <= cnt + 5'd1;
            if (cnt < 5'(NT))
                tile_map_addr <= map_base + 7'(cnt[4:2]);
            else
                tile_map_addr <= '0;
            if (cnt >= 5'd2 && cnt < 5'(NT + 2))
                tile_gfx_addr <= {map_entry[6:0], vcount[TS-1:0]};  // Tile id * 16 + row
            else
                tile_gfx_addr <= '0;
        end else begin
            cnt           <= '0;  // Idle in vblank and display
            tile_map_addr <= '0;
            tile_gfx_addr <= '0;
        end
    end

    // Line tables
    always_ff @(posedge clk) begin
        if (line_phase) begin
            if (cnt >= 5'd2 && cnt < 5'(NT + 2))
                pal_tab[gfx_tile] <= map_entry[7];
            if (cnt >= 5'd4 && cnt < 5'(NT + 4))
                row_tab[cap_tile] <= tile_gfx_data;
        end
    end

    assign bg_row = row_tab[bg_tile_sel];
    assign bg_pal = pal_tab[bg_tile_sel];

endmodule

//--- hdl/sprite_line_fetch.sv
`timescale 1ns/1ns
`include "ppu_settings.svh"

module sprite_line_fetch import ppu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [9:0]  vcount,
    input  logic        vblank,
    input  logic        hsync,
    input  oam_word_u   oam_data,
    input  gfx_row_t    sprite_gfx_data,
    output logic [4:0]  oam_addr,
    output logic [10:0] sprite_gfx_addr,
    sprite_slot_if.source slots
);

    localparam int NS        = `PPU_SPRITES;
    localparam int NSL       = `PPU_SLOTS;
    localparam int SLW       = $clog2(NSL);
    localparam int OAM_WORDS = 2 * NS;
    localparam int SCAN_END  = NS;         // One sprite checked per cycle
    localparam int FETCH_END = NS + NSL;
    localparam int CAP_START = SCAN_END + 2;  // Row data lags its address by two cycles
    localparam int CAP_END   = FETCH_END + 2;

    // Frame tables, filled in vblank
    logic [15:0] x_tab [NS];
    logic [15:0] y_tab [NS];
    logic [6:0]  tile_tab [NS];
    logic [NS-1:0] pal_tab;
    logic [NS-1:0] flip_tab;

    logic [5:0]  oam_cnt;
    logic [4:0]  oam_word;
    logic [4:0]  line_cnt;
    logic [2:0]  found;
    logic [$clog2(NS)-1:0]  scan_idx;
    logic [$clog2(NS)-1:0]  sel_idx [NSL];
    logic [$clog2(NSL)-1:0] fetch_slot;
    logic [$clog2(NSL)-1:0] cap_slot;
    logic [16:0] scan_y_end;
    logic        on_line;
    logic        take;
    logic [3:0]  fetch_fine;
    logic        line_phase;

    function automatic gfx_row_t reverse_row(gfx_row_t row);
        gfx_row_t rev;
        for (int p = 0; p < `PPU_TILE_PX; p++)
            rev[2*p +: 2] = row[2*(`PPU_TILE_PX - 1 - p) +: 2];
        return rev;
    endfunction

    assign line_phase = hsync && !vblank;
    assign oam_word   = oam_cnt[4:0] - 5'd2;  // Address of the word on oam_data

    assign scan_idx   = line_cnt[$clog2(NS)-1:0];
    assign scan_y_end = {1'b0, y_tab[scan_idx]} + 17'(`PPU_TILE_PX);
    assign on_line    = (16'(vcount) >= y_tab[scan_idx]) && (17'(vcount) < scan_y_end);
    assign take       = (line_cnt < 5'(SCAN_END)) && on_line && (found < 3'(NSL));

    assign fetch_slot = SLW'(line_cnt - 5'(SCAN_END));
    assign cap_slot   = SLW'(line_cnt - 5'(CAP_START));
    assign fetch_fine = vcount[3:0] - y_tab[sel_idx[fetch_slot]][3:0];  // Row inside sprite

    // OAM read sequence, 32 words in 34 cycles
    always_ff @(posedge clk) begin
        if (reset) begin
            oam_cnt  <= '0;
            oam_addr <= '0;
        end else if (vblank) begin
            if (oam_cnt < 6'(OAM_WORDS + 2))
                oam_cnt <= oam_cnt + 6'd1;
            oam_addr <= (oam_cnt < 6'(OAM_WORDS)) ? oam_cnt[4:0] : 5'd0;
        end else begin
            oam_cnt  <= '0;
            oam_addr <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (vblank && oam_cnt >= 6'd2 && oam_cnt < 6'(OAM_WORDS + 2)) begin
            if (oam_word[0]) begin  // Coordinate word
                x_tab[oam_word[4:1]] <= oam_data.coord.x;
                y_tab[oam_word[4:1]] <= oam_data.coord.y;
            end else begin
                tile_tab[oam_word[4:1]] <= oam_data.attr.tile;
                pal_tab[oam_word[4:1]]  <= oam_data.attr.pal;
                flip_tab[oam_word[4:1]] <= oam_data.attr.flip;
            end
        end
    end

    // Line search, then row fetch for the chosen slots
    always_ff @(posedge clk) begin
        if (reset) begin
            line_cnt         <= '0;
            found            <= '0;
            sprite_gfx_addr  <= '0;
            slots.slot_valid <= '0;
        end else if (line_phase) begin
            if (line_cnt < 5'(CAP_END))
                line_cnt <= line_cnt + 5'd1;
            if (line_cnt == 5'd0)
                slots.slot_valid <= '0;  // Drop last line's sprites
            if (take) begin
                slots.slot_valid[found[1:0]] <= 1'b1;
                found <= found + 3'd1;
            end
            if (line_cnt >= 5'(SCAN_END) && line_cnt < 5'(FETCH_END))
                sprite_gfx_addr <= {tile_tab[sel_idx[fetch_slot]], fetch_fine};
            else
                sprite_gfx_addr <= '0;
        end else begin
            line_cnt        <= '0;
            found           <= '0;
            sprite_gfx_addr <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (line_phase) begin
            if (take) begin
                sel_idx[found[1:0]]         <= scan_idx;
                slots.slot_x[found[1:0]]    <= x_tab[scan_idx];
                slots.slot_pal[found[1:0]]  <= pal_tab[scan_idx];
                slots.slot_flip[found[1:0]] <= flip_tab[scan_idx];
            end
            if (line_cnt >= 5'(CAP_START) && line_cnt < 5'(CAP_END)) begin
                if (!slots.slot_valid[cap_slot])
                    slots.slot_row[cap_slot] <= '0;
                else if (slots.slot_flip[cap_slot])
                    slots.slot_row[cap_slot] <= reverse_row(sprite_gfx_data);
                else
                    slots.slot_row[cap_slot] <= sprite_gfx_data;
            end
        end
    end

endmodule

//--- hdl/pixel_mixer.sv
`timescale 1ns/1ns
`include "ppu_settings.svh"

module pixel_mixer import ppu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [10:0] hcount,
    input  logic        vblank,
    input  logic        hsync,
    input  color_t      palette_data,
    input  gfx_row_t    bg_row,
    input  logic        bg_pal,
    output logic [2:0]  palette_addr,
    output logic [$clog2(`PPU_TILES_PER_LINE)-1:0] bg_tile_sel,
    output color_t      pixel_color,
    sprite_slot_if.sink slots
);

    localparam int NP  = `PPU_PALETTE_ENTRIES;
    localparam int NSL = `PPU_SLOTS;
    localparam int TS  = $clog2(`PPU_TILE_PX);

    color_t pal_tab [NP];

    logic [3:0]     pal_cnt;
    logic [2:0]     pal_word;
    logic [15:0]    hpos;
    logic [1:0]     bg_pix;
    logic [NSL-1:0] covered;
    logic [1:0]     spr_pix [NSL];
    logic [1:0]     win_pix;
    logic           win_pal;

    // Palette read sequence, 8 words in 10 cycles
    assign pal_word = 3'(pal_cnt - 4'd2);

    always_ff @(posedge clk) begin
        if (reset) begin
            pal_cnt      <= '0;
            palette_addr <= '0;
        end else if (vblank) begin
            if (pal_cnt < 4'(NP + 2))
                pal_cnt <= pal_cnt + 4'd1;
            palette_addr <= (pal_cnt < 4'(NP)) ? pal_cnt[2:0] : 3'd0;
        end else begin
            pal_cnt      <= '0;
            palette_addr <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (vblank && pal_cnt >= 4'd2 && pal_cnt < 4'(NP + 2))
            pal_tab[pal_word] <= palette_data;
    end

    assign hpos        = 16'(hcount);
    assign bg_tile_sel = hcount[TS +: $clog2(`PPU_TILES_PER_LINE)];
    assign bg_pix      = bg_row[{hcount[TS-1:0], 1'b0} +: 2];

    for (genvar s = 0; s < NSL; s++) begin : g_slot
        logic [15:0] dx;
        assign dx = hpos - slots.slot_x[s];
        assign covered[s] = slots.slot_valid[s] && (hpos >= slots.slot_x[s])
                            && (dx < 16'(`PPU_TILE_PX));
        assign spr_pix[s] = slots.slot_row[s][{dx[TS-1:0], 1'b0} +: 2];
    end

    // Lowest opaque slot wins, otherwise the background shows
    always_comb begin
        win_pix = bg_pix;
        win_pal = bg_pal;
        for (int s = NSL - 1; s >= 0; s--) begin
            if (covered[s] && spr_pix[s] != 2'b00) begin
                win_pix = spr_pix[s];
                win_pal = slots.slot_pal[s];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            pixel_color <= '0;
        else if (vblank || hsync)
            pixel_color <= '0;  // Blank outside active display
        else
            pixel_color <= pal_tab[{win_pal, win_pix}];
    end

endmodule

//--- hdl/ppu_top.sv
`timescale 1ns/1ns
`include "ppu_settings.svh"

module ppu_top (
    input  logic        clk,
    input  logic        reset,
    input  logic [10:0] hcount,
    input  logic [9:0]  vcount,
    input  logic        vblank,
    input  logic        hsync,
    input  logic [31:0] tile_map_data,
    input  logic [31:0] tile_gfx_data,
    input  logic [31:0] sprite_gfx_data,
    input  logic [31:0] oam_data,
    input  logic [23:0] palette_data,
    output logic [6:0]  tile_map_addr,
    output logic [10:0] tile_gfx_addr,
    output logic [10:0] sprite_gfx_addr,
    output logic [4:0]  oam_addr,
    output logic [2:0]  palette_addr,
    output logic [23:0] pixel_color
);

    logic [$clog2(`PPU_TILES_PER_LINE)-1:0] bg_tile_sel;
    logic [2*`PPU_TILE_PX-1:0] bg_row;
    logic bg_pal;

    sprite_slot_if slots_if ();

    bg_line_fetch bg_line_fetch_i (
        .clk           (clk),
        .reset         (reset),
        .vcount        (vcount),
        .vblank        (vblank),
        .hsync         (hsync),
        .tile_map_data (tile_map_data),
        .tile_gfx_data (tile_gfx_data),
        .bg_tile_sel   (bg_tile_sel),
        .tile_map_addr (tile_map_addr),
        .tile_gfx_addr (tile_gfx_addr),
        .bg_row        (bg_row),
        .bg_pal        (bg_pal)
    );

    sprite_line_fetch sprite_line_fetch_i (
        .clk             (clk),
        .reset           (reset),
        .vcount          (vcount),
        .vblank          (vblank),
        .hsync           (hsync),
        .oam_data        (oam_data),
        .sprite_gfx_data (sprite_gfx_data),
        .oam_addr        (oam_addr),
        .sprite_gfx_addr (sprite_gfx_addr),
        .slots           (slots_if.source)
    );

    pixel_mixer pixel_mixer_i (
        .clk          (clk),
        .reset        (reset),
        .hcount       (hcount),
        .vblank       (vblank),
        .hsync        (hsync),
        .palette_data (palette_data),
        .bg_row       (bg_row),
        .bg_pal       (bg_pal),
        .palette_addr (palette_addr),
        .bg_tile_sel  (bg_tile_sel),
        .pixel_color  (pixel_color),
        .slots        (slots_if.sink)
    );

endmodule

//--- tests/ppu_ref.svh
`ifndef PPU_REF_SVH
`define PPU_REF_SVH

// One step of a 32-bit xorshift generator
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Background pixel as {palette bit, pixel}
function automatic logic [2:0] bg_pixel(input logic [9:0] v, input logic [10:0] h);
    logic [4:0]  tile;
    logic [6:0]  map_addr;
    logic [7:0]  entry;
    logic [31:0] row;
    tile     = 5'(h / 11'd16);
    map_addr = 7'(v / 10'd16) * 7'd5 + 7'(tile / 5'd4);
    entry    = tile_map_mem[map_addr][{tile[1:0], 3'b000} +: 8];  // Lowest byte is leftmost
    row      = tile_gfx_mem[11'(entry[6:0]) * 11'd16 + 11'(v % 10'd16)];
    return {entry[7], row[{h[3:0], 1'b0} +: 2]};
endfunction

// Winning sprite pixel as {hit, palette bit, pixel}
function automatic logic [3:0] sprite_pixel(input logic [9:0] v, input logic [10:0] h);
    int          taken;
    logic [3:0]  result;
    logic [31:0] coord;
    logic [31:0] attr;
    logic [31:0] row;
    logic [15:0] dx;
    logic [15:0] dy;
    logic [3:0]  idx;
    taken  = 0;
    result = 4'd0;
    for (int n = 0; n < `PPU_SPRITES; n++) begin
        coord = oam_mem[5'(2 * n + 1)];  // y high, x low
        attr  = oam_mem[5'(2 * n)];
        dy    = 16'(v) - coord[31:16];
        dx    = 16'(h) - coord[15:0];
        // Only the first four sprites on the line take part
        if (taken < `PPU_SLOTS && 16'(v) >= coord[31:16] && dy < 16'd16) begin
            taken++;
            if (!result[3] && 16'(h) >= coord[15:0] && dx < 16'd16) begin
                idx = attr[30] ? 4'd15 - dx[3:0] : dx[3:0];
                row = sprite_gfx_mem[11'(attr[6:0]) * 11'd16 + 11'(dy)];
                if (row[{idx, 1'b0} +: 2] != 2'b00)
                    result = {1'b1, attr[7], row[{idx, 1'b0} +: 2]};
            end
        end
    end
    return result;
endfunction

// Expected screen color, palette entry pal * 4 + pixel
function automatic logic [23:0] expected_color(input logic [9:0] v, input logic [10:0] h);
    logic [3:0] spr;
    logic [2:0] bg;
    spr = sprite_pixel(v, h);
    bg  = bg_pixel(v, h);
    if (spr[3])
        return palette_mem[3'(spr[2]) * 3'd4 + 3'(spr[1:0])];
    else
        return palette_mem[3'(bg[2]) * 3'd4 + 3'(bg[1:0])];
endfunction

`endif

//--- tests/ppu_tb.sv
`timescale 1ns/1ns
`include "ppu_settings.svh"

module ppu_tb;

    localparam int LINE_PX = `PPU_TILE_PX * `PPU_TILES_PER_LINE;

    logic        clk;
    logic        reset;
    logic [10:0] hcount;
    logic [9:0]  vcount;
    logic        vblank;
    logic        hsync;
    logic [31:0] tile_map_data;
    logic [31:0] tile_gfx_data;
    logic [31:0] sprite_gfx_data;
    logic [31:0] oam_data;
    logic [23:0] palette_data;
    logic [6:0]  tile_map_addr;
    logic [10:0] tile_gfx_addr;
    logic [10:0] sprite_gfx_addr;
    logic [4:0]  oam_addr;
    logic [2:0]  palette_addr;
    logic [23:0] pixel_color;
    logic [36:0] all_addr;

    logic [31:0] tile_map_mem [128];
    logic [31:0] tile_gfx_mem [2048];
    logic [31:0] sprite_gfx_mem [2048];
    logic [31:0] oam_mem [32];
    logic [23:0] palette_mem [8];
    logic [31:0] rng_state;
    logic [23:0] line_cap [LINE_PX];  // Last swept line

    `include "ppu_ref.svh"

    ppu_top ppu_top_i (.*);

    assign all_addr = {tile_map_addr, tile_gfx_addr, sprite_gfx_addr, oam_addr, palette_addr};

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Memories with one cycle from address to data
    always @(posedge clk) begin
        tile_map_data   <= tile_map_mem[tile_map_addr];
        tile_gfx_data   <= tile_gfx_mem[tile_gfx_addr];
        sprite_gfx_data <= sprite_gfx_mem[sprite_gfx_addr];
        oam_data        <= oam_mem[oam_addr];
        palette_data    <= palette_mem[palette_addr];
    end

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        stop_run($sformatf("ERR %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp));
    endtask

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic place_sprite(input int n, input logic [15:0] x, input logic [15:0] y,
                                input logic [6:0] tile, input logic pal, input logic flip);
        oam_mem[5'(2 * n + 1)] = {y, x};
        oam_mem[5'(2 * n)]     = {1'b0, flip, 22'd0, pal, tile};
    endtask

    task automatic fill_random();
        for (int a = 0; a < 128; a++)
            tile_map_mem[7'(a)] = next_rand();
        for (int a = 0; a < 2048; a++) begin
            tile_gfx_mem[11'(a)]   = next_rand();
            sprite_gfx_mem[11'(a)] = next_rand();
        end
        for (int a = 0; a < `PPU_PALETTE_ENTRIES; a++)
            palette_mem[3'(a)] = 24'(next_rand());
        for (int n = 0; n < `PPU_SPRITES; n++)
            place_sprite(n, 16'd0, 16'd900, 7'(n), 1'b0, 1'b0);  // Far below tested lines
    endtask

    task automatic make_opaque_tile(input logic [6:0] tile);
        logic [31:0] row;
        for (int r = 0; r < `PPU_TILE_PX; r++) begin
            for (int p = 0; p < `PPU_TILE_PX; p++)
                row[5'(2 * p) +: 2] = 2'(next_rand() % 32'd3) + 2'd1;
            sprite_gfx_mem[11'(tile) * 11'd16 + 11'(r)] = row;
        end
    endtask

    // Pixels 0 and 1 of every group of four clear, pixel 3 always opaque
    task automatic mix_tile(input logic [6:0] tile);
        for (int r = 0; r < `PPU_TILE_PX; r++)
            sprite_gfx_mem[11'(tile) * 11'd16 + 11'(r)] =
                (sprite_gfx_mem[11'(tile) * 11'd16 + 11'(r)] & 32'hf0f0_f0f0) | 32'h4040_4040;
    endtask

    task automatic load_frame();
        int oam_last;
        int pal_last;
        oam_last = -1;
        pal_last = -1;
        for (int i = 0; i < 64; i++) begin
            @(posedge clk);
            vblank <= 1'b1;
            hsync  <= 1'b0;
            @(negedge clk);
            if (oam_addr == 5'd31 && oam_last < 0)
                oam_last = i;
            if (palette_addr == 3'd7 && pal_last < 0)
                pal_last = i;
            if (i > 0)
                assert (pixel_color == 24'd0)
                    else report_mismatch("pixel_color in vblank", 64'(pixel_color), 64'd0);
        end
        assert (oam_last >= 0 && oam_last <= 40)
            else stop_run("OAM load did not reach the last word within 40 cycles of vblank");
        assert (pal_last >= 0 && pal_last <= 12)
            else stop_run("Palette load did not reach the last entry within 12 cycles");
    endtask

    task automatic fetch_line(input logic [9:0] v);
        for (int i = 0; i < 48; i++) begin
            @(posedge clk);
            vblank <= 1'b0;
            hsync  <= 1'b1;
            vcount <= v;
            @(negedge clk);
            if (i > 0)
                assert (pixel_color == 24'd0)
                    else report_mismatch("pixel_color in hsync", 64'(pixel_color), 64'd0);
        end
    endtask

    // Color for hcount h shows one cycle after h is sampled
    task automatic sweep_line(input logic [9:0] v);
        logic [23:0] exp;
        @(posedge clk);
        hsync  <= 1'b0;
        hcount <= 11'd0;
        for (int h = 0; h < LINE_PX; h++) begin
            @(posedge clk);
            hcount <= (h < LINE_PX - 1) ? 11'(h + 1) : 11'd0;
            @(negedge clk);
            exp = expected_color(v, 11'(h));
            line_cap[9'(h)] = pixel_color;
            assert (pixel_color == exp)
                else report_mismatch($sformatf("pixel_color at vcount %0d hcount %0d", v, h),
                                     64'(pixel_color), 64'(exp));
        end
    endtask

    task automatic check_line(input logic [9:0] v);
        fetch_line(v);
        sweep_line(v);
    endtask

    task automatic reset_test();
        assert (pixel_color == 24'd0)
            else report_mismatch("pixel_color after reset", 64'(pixel_color), 64'd0);
        assert (all_addr == 37'd0)
            else report_mismatch("memory addresses after reset", 64'(all_addr), 64'd0);
        load_frame();  // Both windows check for a blank output
        fetch_line(10'd5);
    endtask

    task automatic background_test();
        load_frame();
        check_line(10'd37);
        check_line(10'd203);
    endtask

    task automatic overlay_test();
        mix_tile(7'd3);
        mix_tile(7'd9);
        place_sprite(0, 16'd40, 16'd96, 7'd3, 1'b1, 1'b0);
        place_sprite(1, 16'd120, 16'd100, 7'd9, 1'b0, 1'b0);
        load_frame();
        check_line(10'd104);
        check_line(10'd110);
    endtask

    task automatic flip_test();
        logic [23:0] first_line [LINE_PX];
        make_opaque_tile(7'd20);
        place_sprite(0, 16'd64, 16'd160, 7'd20, 1'b0, 1'b0);
        place_sprite(1, 16'd64, 16'd176, 7'd20, 1'b0, 1'b1);
        load_frame();
        check_line(10'd165);  // Same tile row on both lines
        first_line = line_cap;
        check_line(10'd181);
        for (int i = 0; i < `PPU_TILE_PX; i++)
            assert (line_cap[9'(64 + i)] == first_line[9'(79 - i)])
                else report_mismatch($sformatf("pixel_color at hcount %0d of flipped line",
                                               64 + i),
                                     64'(line_cap[9'(64 + i)]), 64'(first_line[9'(79 - i)]));
    endtask

    task automatic slot_limit_test();
        fill_random();
        make_opaque_tile(7'd34);
        make_opaque_tile(7'd35);
        place_sprite(0, 16'd100, 16'd240, 7'd30, 1'b0, 1'b0);
        place_sprite(1, 16'd108, 16'd245, 7'd31, 1'b1, 1'b0);
        place_sprite(2, 16'd104, 16'd238, 7'd32, 1'b1, 1'b1);
        place_sprite(3, 16'd200, 16'd250, 7'd33, 1'b0, 1'b0);
        place_sprite(4, 16'd102, 16'd236, 7'd34, 1'b1, 1'b0);  // Beyond the slot limit
        place_sprite(5, 16'd260, 16'd249, 7'd35, 1'b0, 1'b0);
        load_frame();
        check_line(10'd250);
    endtask

    initial begin
        rng_state = 32'd57823;
        reset  <= 1'b1;
        hcount <= '0;
        vcount <= '0;
        vblank <= 1'b0;
        hsync  <= 1'b0;
        fill_random();
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        reset_test();
        background_test();
        overlay_test();
        flip_test();
        slot_limit_test();
        $display("SIMULATION PASSED");
        $finish;
    end

    initial begin
        repeat (50000) @(posedge clk);
        stop_run("Simulation did not finish within 50000 cycles");
    end

endmodule

//--- files.f
+incdir+hdl
+incdir+tests
hdl/ppu_pkg.sv
hdl/sprite_slot_if.sv
hdl/bg_line_fetch.sv
hdl/sprite_line_fetch.sv
hdl/pixel_mixer.sv
hdl/ppu_top.sv
tests/ppu_tb.sv

//--- Makefile
.PHONY: run build lint clean

run: build
	@out="$$(./obj_dir/Vppu_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

build:
	verilator --binary --timing --assert -f files.f --top-module ppu_tb -o Vppu_tb

lint:
	verilator --lint-only --timing --assert -f files.f --top-module ppu_tb

clean:
	rm -rf obj_dir
